// File: design/cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

   // front end, word side of the cache
   localparam int FE_ADDR_W = 32;   // byte address
   localparam int FE_DATA_W = 32;
   localparam int FE_NBYTES = 4;    // strobe width

   // back end, memory bus side
   localparam int BE_DATA_W   = 64;
   localparam int BE_NBYTES   = 8;
   localparam int BE_NBYTES_W = 3;  // also the awsize code

   // write buffer geometry
   localparam int BUF_DEPTH = 4;
   localparam int BUF_PTR_W = 2;

endpackage

`default_nettype wire

// File: design/axi_defs_pkg.sv
`default_nettype none

package axi_defs_pkg;

   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01
   } axi_burst_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } axi_resp_e;

   // write master states
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_ADDR = 2'd1,   // aw phase
      ST_DATA = 2'd2,   // w phase
      ST_RESP = 2'd3    // waiting on b
   } wr_state_e;

   localparam int AXI_ID_W             = 4;
   localparam int AXI_ID               = 0;
   localparam int AXI_LEN_W            = 8;
   localparam int AXI_CACHE_BUFFERABLE = 3;   // bufferable, modifiable

endpackage

`default_nettype wire

// File: design/write_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module write_buffer
   import cache_cfg_pkg::*;
(
   input  wire                  clk_i,
   input  wire                  reset,
   input  wire                  push_i,
   input  wire  [FE_ADDR_W-1:0] push_addr_i,
   input  wire  [FE_DATA_W-1:0] push_wdata_i,
   input  wire  [FE_NBYTES-1:0] push_wstrb_i,
   input  wire                  pop_i,
   output logic [FE_ADDR_W-1:0] head_addr_o,
   output logic [FE_DATA_W-1:0] head_wdata_o,
   output logic [FE_NBYTES-1:0] head_wstrb_o,
   output logic                 empty_o,
   output logic                 full_o
);

   logic [FE_ADDR_W-1:0] addr_mem  [BUF_DEPTH];
   logic [FE_DATA_W-1:0] wdata_mem [BUF_DEPTH];
   logic [FE_NBYTES-1:0] wstrb_mem [BUF_DEPTH];

   logic [BUF_PTR_W-1:0] wr_ptr;
   logic [BUF_PTR_W-1:0] rd_ptr;
   logic [BUF_PTR_W:0]   count;
   logic [BUF_PTR_W:0]   count_nxt;
   logic                 do_push;
   logic                 do_pop;

   assign do_push = push_i & ~full_o;   // write while full is lost
   assign do_pop  = pop_i & ~empty_o;

   always_comb begin
      count_nxt = count;
      if (do_push && !do_pop) begin
         count_nxt = count + 1'b1;
      end else if (do_pop && !do_push) begin
         count_nxt = count - 1'b1;
      end
   end

   // entry storage
   always_ff @(posedge clk_i) begin
      if (do_push) begin
         addr_mem[wr_ptr]  <= push_addr_i;
         wdata_mem[wr_ptr] <= push_wdata_i;
         wstrb_mem[wr_ptr] <= push_wstrb_i;
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         empty_o <= 1'b1;
         full_o  <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count   <= count_nxt;
         empty_o <= (count_nxt == '0);
         full_o  <= (count_nxt == (BUF_PTR_W + 1)'(BUF_DEPTH));
      end
   end

   // show-ahead head, held until popped
   assign head_addr_o  = addr_mem[rd_ptr];
   assign head_wdata_o = wdata_mem[rd_ptr];
   assign head_wstrb_o = wstrb_mem[rd_ptr];

endmodule

`default_nettype wire

// File: design/axi_write_channel.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_channel
   import cache_cfg_pkg::*;
   import axi_defs_pkg::*;
(
   input  wire                  clk_i,
   input  wire                  reset,
   input  wire                  valid_i,
   input  wire  [FE_ADDR_W-1:0] addr_i,
   input  wire  [FE_DATA_W-1:0] wdata_i,
   input  wire  [FE_NBYTES-1:0] wstrb_i,
   output logic                 pop_o,
   output logic                 idle_o,
   output logic [AXI_ID_W-1:0]  axi_awid_o,
   output logic [FE_ADDR_W-1:0] axi_awaddr_o,
   output logic [AXI_LEN_W-1:0] axi_awlen_o,
   output logic [2:0]           axi_awsize_o,
   output logic [1:0]           axi_awburst_o,
   output logic                 axi_awlock_o,
   output logic [3:0]           axi_awcache_o,
   output logic [2:0]           axi_awprot_o,
   output logic [3:0]           axi_awqos_o,
   output logic                 axi_awvalid_o,
   input  wire                  axi_awready_i,
   output logic [BE_DATA_W-1:0] axi_wdata_o,
   output logic [BE_NBYTES-1:0] axi_wstrb_o,
   output logic                 axi_wlast_o,
   output logic                 axi_wvalid_o,
   input  wire                  axi_wready_i,
   input  wire  [1:0]           axi_bresp_i,
   input  wire                  axi_bvalid_i,
   output logic                 axi_bready_o
);

   wr_state_e state_q;
   wr_state_e state_d;
   logic      resp_ok;

   // fixed attributes of every write
   assign axi_awid_o    = AXI_ID_W'(AXI_ID);
   assign axi_awlen_o   = AXI_LEN_W'(0);             // single beat
   assign axi_awsize_o  = 3'(BE_NBYTES_W);           // full bus word
   assign axi_awburst_o = BURST_FIXED;
   assign axi_awlock_o  = 1'b0;                      // normal access
   assign axi_awcache_o = 4'(AXI_CACHE_BUFFERABLE);
   assign axi_awprot_o  = 3'b000;
   assign axi_awqos_o   = 4'b0000;

   // bus word aligned address
   assign axi_awaddr_o = {addr_i[FE_ADDR_W-1:BE_NBYTES_W], {BE_NBYTES_W{1'b0}}};

   // word goes on both lanes, strobes pick the half
   assign axi_wdata_o = {2{wdata_i}};
   assign axi_wstrb_o = addr_i[BE_NBYTES_W-1] ? {wstrb_i, {FE_NBYTES{1'b0}}}
                                              : {{FE_NBYTES{1'b0}}, wstrb_i};
   assign axi_wlast_o = axi_wvalid_o;

   assign resp_ok = axi_bvalid_i && (axi_bresp_i == RESP_OKAY);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (valid_i) begin
               state_d = ST_ADDR;
            end
         end
         ST_ADDR: begin
            if (!valid_i) begin
               state_d = ST_IDLE;   // buffer drained by last pop
            end else if (axi_awready_i) begin
               state_d = ST_DATA;
            end
         end
         ST_DATA: begin
            if (axi_wready_i) begin
               state_d = ST_RESP;
            end
         end
         default: begin
            // error response resends the same head entry
            if (axi_bvalid_i) begin
               state_d = ST_ADDR;
            end
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // awvalid only with a head entry present
   assign axi_awvalid_o = (state_q == ST_ADDR) && valid_i;
   assign axi_wvalid_o  = (state_q == ST_DATA);
   assign axi_bready_o  = (state_q == ST_RESP);
   assign pop_o         = (state_q == ST_RESP) && resp_ok;
   assign idle_o        = (state_q == ST_IDLE);

endmodule

`default_nettype wire

// File: design/cache_write_back_end.sv
`timescale 1ns/1ps
`default_nettype none

module cache_write_back_end
   import cache_cfg_pkg::*;
   import axi_defs_pkg::*;
(
   input  wire                  clk_i,
   input  wire                  reset,
   input  wire                  fe_valid_i,
   input  wire  [FE_ADDR_W-1:0] fe_addr_i,
   input  wire  [FE_DATA_W-1:0] fe_wdata_i,
   input  wire  [FE_NBYTES-1:0] fe_wstrb_i,
   output logic                 fe_ready_o,
   output logic                 idle_o,
   output logic [AXI_ID_W-1:0]  axi_awid_o,
   output logic [FE_ADDR_W-1:0] axi_awaddr_o,
   output logic [AXI_LEN_W-1:0] axi_awlen_o,
   output logic [2:0]           axi_awsize_o,
   output logic [1:0]           axi_awburst_o,
   output logic                 axi_awlock_o,
   output logic [3:0]           axi_awcache_o,
   output logic [2:0]           axi_awprot_o,
   output logic [3:0]           axi_awqos_o,
   output logic                 axi_awvalid_o,
   input  wire                  axi_awready_i,
   output logic [BE_DATA_W-1:0] axi_wdata_o,
   output logic [BE_NBYTES-1:0] axi_wstrb_o,
   output logic                 axi_wlast_o,
   output logic                 axi_wvalid_o,
   input  wire                  axi_wready_i,
   input  wire  [1:0]           axi_bresp_i,
   input  wire                  axi_bvalid_i,
   output logic                 axi_bready_o
);

   logic [FE_ADDR_W-1:0] head_addr;
   logic [FE_DATA_W-1:0] head_wdata;
   logic [FE_NBYTES-1:0] head_wstrb;
   logic                 buf_empty;
   logic                 buf_full;
   logic                 wr_pop;
   logic                 ch_idle;

   write_buffer wbuf0 (
      .clk_i        (clk_i),
      .reset        (reset),
      .push_i       (fe_valid_i),   // dropped when full
      .push_addr_i  (fe_addr_i),
      .push_wdata_i (fe_wdata_i),
      .push_wstrb_i (fe_wstrb_i),
      .pop_i        (wr_pop),
      .head_addr_o  (head_addr),
      .head_wdata_o (head_wdata),
      .head_wstrb_o (head_wstrb),
      .empty_o      (buf_empty),
      .full_o       (buf_full)
   );

   axi_write_channel wch0 (
      .clk_i         (clk_i),
      .reset         (reset),
      .valid_i       (~buf_empty),
      .addr_i        (head_addr),
      .wdata_i       (head_wdata),
      .wstrb_i       (head_wstrb),
      .pop_o         (wr_pop),
      .idle_o        (ch_idle),
      .axi_awid_o    (axi_awid_o),
      .axi_awaddr_o  (axi_awaddr_o),
      .axi_awlen_o   (axi_awlen_o),
      .axi_awsize_o  (axi_awsize_o),
      .axi_awburst_o (axi_awburst_o),
      .axi_awlock_o  (axi_awlock_o),
      .axi_awcache_o (axi_awcache_o),
      .axi_awprot_o  (axi_awprot_o),
      .axi_awqos_o   (axi_awqos_o),
      .axi_awvalid_o (axi_awvalid_o),
      .axi_awready_i (axi_awready_i),
      .axi_wdata_o   (axi_wdata_o),
      .axi_wstrb_o   (axi_wstrb_o),
      .axi_wlast_o   (axi_wlast_o),
      .axi_wvalid_o  (axi_wvalid_o),
      .axi_wready_i  (axi_wready_i),
      .axi_bresp_i   (axi_bresp_i),
      .axi_bvalid_i  (axi_bvalid_i),
      .axi_bready_o  (axi_bready_o)
   );

   assign fe_ready_o = ~buf_full;
   assign idle_o     = ch_idle & buf_empty;   // no write pending anywhere

endmodule

`default_nettype wire

// File: tests/axi_mem_responder.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_responder
   import axi_defs_pkg::*;
(
   input  wire         clk_i,
   input  wire         reset,
   input  wire         stall_i,       // holds awready low
   input  wire         err_valid_i,
   input  wire  [1:0]  err_cnt_i,
   input  wire  [31:0] awaddr_i,
   input  wire         awvalid_i,
   output logic        awready_o,
   input  wire  [63:0] wdata_i,
   input  wire  [7:0]  wstrb_i,
   input  wire         wvalid_i,
   output logic        wready_o,
   output logic [1:0]  bresp_o,
   output logic        bvalid_o,
   input  wire         bready_i
);

   logic [63:0] mem [64];
   logic [1:0]  err_q [$];
   logic [1:0]  phase;       // 0 aw, 1 w, 2 b
   logic [1:0]  wait_cnt;
   logic [31:0] lcg;
   logic [5:0]  word_idx;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   assign awready_o = (phase == 2'd0) && (wait_cnt == 2'd0) && !stall_i;
   assign wready_o  = (phase == 2'd1) && (wait_cnt == 2'd0);

   always @(posedge clk_i or posedge reset) begin
      if (reset) begin
         phase    <= 2'd0;
         wait_cnt <= 2'd0;
         lcg      <= 32'd74;
         bvalid_o <= 1'b0;
         bresp_o  <= RESP_OKAY;
         word_idx <= 6'd0;
         err_q.delete();
         for (int i = 0; i < 64; i++) begin
            mem[i] <= 64'd0;
         end
      end else begin
         if (err_valid_i) begin
            err_q.push_back(err_cnt_i);
         end
         if (phase != 2'd2 && wait_cnt != 2'd0 && (awvalid_i || wvalid_i)) begin
            wait_cnt <= wait_cnt - 2'd1;
         end
         if (awvalid_i && awready_o) begin
            word_idx <= awaddr_i[8:3];
            phase    <= 2'd1;
            lcg      <= lcg_next(lcg);
            wait_cnt <= lcg[17:16];
         end else if (wvalid_i && wready_o) begin
            bvalid_o <= 1'b1;
            phase    <= 2'd2;
            if (err_q.size() > 0 && err_q[0] != 2'd0) begin
               err_q[0] = err_q[0] - 2'd1;   // one more error to give
               bresp_o <= RESP_SLVERR;
            end else begin
               bresp_o <= RESP_OKAY;
               if (err_q.size() > 0) begin
                  void'(err_q.pop_front());
               end
               for (int b = 0; b < 8; b++) begin
                  if (wstrb_i[b]) begin
                     mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                  end
               end
            end
         end else if (bvalid_o && bready_i) begin
            bvalid_o <= 1'b0;
            phase    <= 2'd0;
            lcg      <= lcg_next(lcg);
            wait_cnt <= lcg[17:16];
         end
      end
   end

endmodule

`default_nettype wire

// File: tests/tb_cache_write_back_end.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_write_back_end
   import cache_cfg_pkg::*;
   import axi_defs_pkg::*;
();

   localparam int N_ROWS      = 16;
   localparam int BURST_ROW   = 10;   // rows from here go back to back under stall
   localparam int TIMEOUT_CYC = N_ROWS * 3 * (4 + 2 * 3) + N_ROWS * 4 + 256;

   logic clk_i;
   logic reset;
   logic fe_valid_i;
   logic [31:0] fe_addr_i;
   logic [31:0] fe_wdata_i;
   logic [3:0]  fe_wstrb_i;
   logic [1:0]  err_cnt;
   logic        stall;
   wire         fe_ready_o, idle_o;
   wire  [3:0]  awid, awcache, awqos;
   wire  [31:0] awaddr;
   wire  [7:0]  awlen, wstrb;
   wire  [2:0]  awsize, awprot;
   wire  [1:0]  awburst, bresp;
   wire         awlock, awvalid, awready, wlast, wvalid, wready, bvalid, bready;
   wire  [63:0] wdata;

   logic [31:0] tbl_addr [N_ROWS] = '{32'h000, 32'h004, 32'h008, 32'h00C, 32'h010, 32'h014,
      32'h010, 32'h104, 32'h108, 32'h1F8, 32'h020, 32'h024, 32'h028, 32'h02C, 32'h020, 32'h1FC};
   logic [31:0] tbl_data [N_ROWS] = '{32'h11223344, 32'h55667788, 32'hA5A5A5A5, 32'hDEADBEEF,
      32'h01020304, 32'hCAFEF00D, 32'h99887766, 32'h0BADC0DE, 32'h13579BDF, 32'h2468ACE0,
      32'hFEDCBA98, 32'h76543210, 32'h0F0F0F0F, 32'hF0E1D2C3, 32'h5A5A5A5A, 32'h87654321};
   logic [3:0]  tbl_strb [N_ROWS] = '{4'hF, 4'hF, 4'h3, 4'hC, 4'h1, 4'h8, 4'h6, 4'hF,
      4'h5, 4'hA, 4'hF, 4'hF, 4'h9, 4'h3, 4'h4, 4'hF};
   logic [1:0]  tbl_err [N_ROWS] = '{2'd0, 2'd1, 2'd0, 2'd2, 2'd0, 2'd0, 2'd1, 2'd0,
      2'd0, 2'd2, 2'd0, 2'd0, 2'd1, 2'd0, 2'd0, 2'd0};
   int          tbl_gap [N_ROWS] = '{1, 0, 3, 2, 0, 1, 0, 2, 1, 3, 0, 0, 0, 0, 0, 0};

   logic [63:0] ref_mem [64];
   int          exp_q [$];    // rows sent, oldest first
   int          attempts;
   int          push_cnt;
   int          done_cnt;
   int          cycles;
   logic        saw_full;

   cache_write_back_end dut0 (
      .clk_i(clk_i), .reset(reset),
      .fe_valid_i(fe_valid_i), .fe_addr_i(fe_addr_i), .fe_wdata_i(fe_wdata_i),
      .fe_wstrb_i(fe_wstrb_i), .fe_ready_o(fe_ready_o), .idle_o(idle_o),
      .axi_awid_o(awid), .axi_awaddr_o(awaddr), .axi_awlen_o(awlen), .axi_awsize_o(awsize),
      .axi_awburst_o(awburst), .axi_awlock_o(awlock), .axi_awcache_o(awcache),
      .axi_awprot_o(awprot), .axi_awqos_o(awqos), .axi_awvalid_o(awvalid),
      .axi_awready_i(awready), .axi_wdata_o(wdata), .axi_wstrb_o(wstrb),
      .axi_wlast_o(wlast), .axi_wvalid_o(wvalid), .axi_wready_i(wready),
      .axi_bresp_i(bresp), .axi_bvalid_i(bvalid), .axi_bready_o(bready)
   );

   axi_mem_responder mem0 (
      .clk_i(clk_i), .reset(reset), .stall_i(stall),
      .err_valid_i(fe_valid_i), .err_cnt_i(err_cnt),
      .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
      .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
      .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready)
   );

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         $display("Test FAILED");
         $fatal(1);
      end
   endtask

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYC) begin
         $display("run timed out after %0d cycles without finishing", cycles);
         $display("Test FAILED");
         $fatal(1);
      end
   end

   // bus monitor, sampled mid cycle
   always @(negedge clk_i) begin
      int r;
      if (!reset && exp_q.size() > 0) begin
         r = exp_q[0];
         if (awvalid && awready) begin
            check("awaddr", 64'(awaddr), 64'({tbl_addr[r][31:3], 3'b000}));
            check("awlen", 64'(awlen), 64'd0);
            check("awsize", 64'(awsize), 64'd3);
            check("awburst", 64'(awburst), 64'(BURST_FIXED));
            check("awid", 64'(awid), 64'd0);
            check("awlock", 64'(awlock), 64'd0);
            check("awcache", 64'(awcache), 64'd3);
            check("awprot", 64'(awprot), 64'd0);
            check("awqos", 64'(awqos), 64'd0);
            attempts = attempts + 1;
         end
         if (wvalid && wready) begin
            check("wlast", 64'(wlast), 64'd1);
            check("wdata", wdata, {tbl_data[r], tbl_data[r]});
            check("wstrb", 64'(wstrb),
                  tbl_addr[r][2] ? 64'({tbl_strb[r], 4'h0}) : 64'(tbl_strb[r]));
         end
         if (bvalid && bready && bresp == RESP_OKAY) begin
            check("attempts", 64'(attempts), 64'(tbl_err[r]) + 64'd1);
            void'(exp_q.pop_front());
            attempts = 0;
            done_cnt = done_cnt + 1;
         end
      end else if (!reset && (awvalid && awready)) begin
         $display("AW handshake seen with no write outstanding");
         $display("Test FAILED");
         $fatal(1);
      end
   end

   initial begin
      reset = 1'b1;
      fe_valid_i = 1'b0;
      fe_addr_i = '0;
      fe_wdata_i = '0;
      fe_wstrb_i = '0;
      err_cnt = '0;
      stall = 1'b0;
      cycles = 0;
      attempts = 0;
      push_cnt = 0;
      done_cnt = 0;
      saw_full = 1'b0;
      for (int i = 0; i < 64; i++) ref_mem[i] = 64'd0;
      repeat (8) @(posedge clk_i);
      #2 reset = 1'b0;
      check("awvalid", 64'(awvalid), 64'd0);
      check("wvalid", 64'(wvalid), 64'd0);
      check("bready", 64'(bready), 64'd0);
      check("fe_ready", 64'(fe_ready_o), 64'd1);
      check("idle", 64'(idle_o), 64'd1);

      for (int r = 0; r < N_ROWS; r++) begin
         if (r == BURST_ROW) stall = 1'b1;
         while (!fe_ready_o) begin
            if (stall) begin
               check("pending_at_full", 64'(push_cnt - done_cnt), 64'd4);
               saw_full = 1'b1;
               stall = 1'b0;
            end
            @(posedge clk_i);
            #2;
         end
         fe_valid_i = 1'b1;
         fe_addr_i = tbl_addr[r];
         fe_wdata_i = tbl_data[r];
         fe_wstrb_i = tbl_strb[r];
         err_cnt = tbl_err[r];
         exp_q.push_back(r);
         push_cnt = push_cnt + 1;
         for (int b = 0; b < 4; b++) begin
            if (tbl_strb[r][b]) begin
               ref_mem[tbl_addr[r][8:3]][(tbl_addr[r][2] * 4 + b) * 8 +: 8] =
                  tbl_data[r][b*8 +: 8];
            end
         end
         @(posedge clk_i);
         #2 fe_valid_i = 1'b0;
         check("idle", 64'(idle_o), 64'd0);   // entry just pushed is pending
         repeat (tbl_gap[r]) @(posedge clk_i);
         if (tbl_gap[r] > 0) #2;
      end
      stall = 1'b0;

      while (!(idle_o && done_cnt == N_ROWS)) begin
         @(posedge clk_i);
         #2;
      end
      for (int i = 0; i < 64; i++) begin
         check($sformatf("mem[%0d]", i), mem0.mem[i], ref_mem[i]);
      end

      if (saw_full) begin
         $display("Test OK");
         $finish;
      end else begin
         $display("fe_ready_o never dropped during the stalled burst");
         $display("Test FAILED");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

// File: compile.f
design/cache_cfg_pkg.sv
design/axi_defs_pkg.sv
design/write_buffer.sv
design/axi_write_channel.sv
design/cache_write_back_end.sv
tests/axi_mem_responder.sv
tests/tb_cache_write_back_end.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_write_back_end
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
